// File: rtl/mvu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Widths and latencies for a single matrix-vector unit
// Segment lengths are stored as the actual length minus 1
// ~~~~~~~~~~~~~~~~~~~~
package mvu_pkg;

    // Word and element geometry
    localparam int N_LANES = 4;                 // Elements per memory word
    localparam int BELEM   = 8;                 // Bits per element
    localparam int BWORD   = N_LANES * BELEM;   // Bits per memory word

    // Address and configuration widths
    localparam int BADDR   = 6;                 // 64 words per memory
    localparam int BCNTDWN = 8;
    localparam int BLENGTH = 4;
    localparam int BACC    = 24;
    localparam int BSCALER = 8;

    // Pipeline latencies
    localparam int MEMRDLATENCY  = 1;
    localparam int VVPSTAGES     = 1;
    localparam int SCALERLATENCY = 1;

    // Run cycle to accumulator input
    localparam int ACC_DELAY = MEMRDLATENCY + VVPSTAGES;

    // Run cycle to the write of its output
    localparam int PIPE_DEPTH = MEMRDLATENCY + VVPSTAGES + SCALERLATENCY + 1;

    typedef logic [BADDR-1:0]   addr_t;
    typedef logic [BWORD-1:0]   word_t;
    typedef logic [BLENGTH-1:0] len_t;
    typedef logic [BCNTDWN-1:0] cnt_t;
    typedef logic [BACC-1:0]    acc_t;
    typedef logic [BSCALER-1:0] scaler_t;

    // Countdown controller states
    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } ctrl_state_t;

endpackage

// File: rtl/mvu_param_buf.sv
// ~~~~~~~~~~~~~~~~~~~~
// Job registers load on start and hold for the whole job
// Host may change its inputs once start has been sampled
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mvu_param_buf import mvu_pkg::*; (
    input  logic    mvu_ext,
    input  logic    rst,
    input  logic    start,
    input  cnt_t    countdown,
    input  addr_t   wbaseaddr,
    input  addr_t   ibaseaddr,
    input  addr_t   obaseaddr,
    input  len_t    wlength,
    input  len_t    ilength,
    input  addr_t   wjump,
    input  addr_t   ijump,
    input  scaler_t scaler_b,
    output logic    start_q,
    output cnt_t    countdown_q,
    output addr_t   wbaseaddr_q,
    output addr_t   ibaseaddr_q,
    output addr_t   obaseaddr_q,
    output len_t    wlength_q,
    output len_t    ilength_q,
    output addr_t   wjump_q,
    output addr_t   ijump_q,
    output scaler_t scaler_b_q
);

    // Start lines up with the freshly loaded registers
    always_ff @(posedge mvu_ext) begin
        if (rst) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    always_ff @(posedge mvu_ext) begin
        if (rst) begin
            countdown_q <= '0;
            wbaseaddr_q <= '0;
            ibaseaddr_q <= '0;
            obaseaddr_q <= '0;
            wlength_q   <= '0;
            ilength_q   <= '0;
            wjump_q     <= '0;
            ijump_q     <= '0;
            scaler_b_q  <= '0;
        end else if (start) begin
            countdown_q <= countdown;
            wbaseaddr_q <= wbaseaddr;
            ibaseaddr_q <= ibaseaddr;
            obaseaddr_q <= obaseaddr;
            wlength_q   <= wlength;       // Actual length minus 1
            ilength_q   <= ilength;
            wjump_q     <= wjump;
            ijump_q     <= ijump;
            scaler_b_q  <= scaler_b;
        end
    end

endmodule

// File: rtl/mvu_controller.sv
// ~~~~~~~~~~~~~~~~~~~~
// Run is high for countdown cycles from start_q
// A start_q while running restarts the count
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mvu_controller import mvu_pkg::*; (
    input  logic mvu_ext,
    input  logic rst,
    input  logic start_q,
    input  cnt_t countdown,
    output logic run,
    output logic done,
    output logic irq
);

    ctrl_state_t state;
    cnt_t        remaining;         // Run cycles left after this one

    // First run cycle coincides with start_q
    assign run = (state == ST_RUN) | (start_q & (countdown != '0));

    always_ff @(posedge mvu_ext) begin
        if (rst) begin
            state     <= ST_IDLE;
            remaining <= '0;
            done      <= 1'b0;
            irq       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start_q) begin
                irq <= 1'b0;
                if (countdown > cnt_t'(1)) begin
                    state     <= ST_RUN;
                    remaining <= countdown - cnt_t'(1);
                end else begin
                    state <= ST_IDLE;   // Zero or one run cycle
                    done  <= 1'b1;
                    irq   <= 1'b1;
                end
            end else if (state == ST_RUN) begin
                if (remaining == cnt_t'(1)) begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                    irq   <= 1'b1;
                end else begin
                    remaining <= remaining - cnt_t'(1);
                end
            end
        end
    end

endmodule

// File: rtl/mvu_agu.sv
// ~~~~~~~~~~~~~~~~~~~~
// Steps by 1 inside a segment and by jump at its last element
// Address is combinational and reads offset 0 while clr is high
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mvu_agu import mvu_pkg::*; (
    input  logic  mvu_ext,
    input  logic  rst,
    input  logic  clr,
    input  logic  step,
    input  addr_t base,
    input  len_t  length,
    input  addr_t jump,
    output addr_t addr,
    output logic  on_j
);

    addr_t off_q;
    len_t  cnt_q;                   // Position inside the segment
    addr_t cur_off;
    len_t  cur_cnt;

    // Clear and first step arrive in the same cycle
    assign cur_off = clr ? '0 : off_q;
    assign cur_cnt = clr ? '0 : cnt_q;

    assign on_j = step & (cur_cnt == length);
    assign addr = base + cur_off;   // Wraps within the memory

    always_ff @(posedge mvu_ext) begin
        if (rst) begin
            off_q <= '0;
            cnt_q <= '0;
        end else if (step) begin
            if (on_j) begin
                off_q <= cur_off + jump;
                cnt_q <= '0;
            end else begin
                off_q <= cur_off + addr_t'(1);
                cnt_q <= cur_cnt + len_t'(1);
            end
        end else if (clr) begin
            off_q <= '0;
            cnt_q <= '0;
        end
    end

endmodule

// File: rtl/mvu_ctrl_delay.sv
// ~~~~~~~~~~~~~~~~~~~~
// Fixed retiming of accumulator controls
// Depth equals memory read plus dot-product latency
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mvu_ctrl_delay import mvu_pkg::*; (
    input  logic mvu_ext,
    input  logic rst,
    input  logic start_q,
    input  logic run,
    input  logic w_on_j,
    output logic acc_clr,
    output logic acc_en,
    output logic seg_end
);

    // Bit 2 clear, bit 1 enable, bit 0 segment end
    logic [2:0] pipe [ACC_DELAY];

    always_ff @(posedge mvu_ext) begin
        if (rst) begin
            for (int i = 0; i < ACC_DELAY; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= {start_q, run, w_on_j};
            for (int i = 1; i < ACC_DELAY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign acc_clr = pipe[ACC_DELAY-1][2];
    assign acc_en  = pipe[ACC_DELAY-1][1];
    assign seg_end = pipe[ACC_DELAY-1][0];    // Last weight of the segment reaches the adder

endmodule

// File: rtl/mvu_data_mem.sv
// ~~~~~~~~~~~~~~~~~~~~
// One write per cycle, writeback wins over the host
// Both read ports are registered
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mvu_data_mem import mvu_pkg::*; (
    input  logic  mvu_ext,
    input  addr_t rdd_addr,
    output word_t rdd_word,
    input  logic  wb_en,
    input  addr_t wb_addr,
    input  word_t wb_word,
    input  logic  wrc_en,
    input  addr_t wrc_addr,
    input  word_t wrc_word,
    output logic  wrc_grnt,
    input  logic  rdc_en,
    input  addr_t rdc_addr,
    output word_t rdc_word
);

    word_t mem [2**BADDR];

    // Host loses the port while writeback is active
    assign wrc_grnt = ~wb_en;

    always_ff @(posedge mvu_ext) begin
        if (wb_en) begin
            mem[wb_addr] <= wb_word;
        end else if (wrc_en) begin
            mem[wrc_addr] <= wrc_word;
        end
    end

    always_ff @(posedge mvu_ext) begin
        rdd_word <= mem[rdd_addr];    // Read every cycle for the pipeline
        if (rdc_en) begin
            rdc_word <= mem[rdc_addr];
        end
    end

endmodule

// File: rtl/mvu_datapath.sv
// ~~~~~~~~~~~~~~~~~~~~
// Lanes are unsigned, results wrap modulo 2^32
// Outputs go to consecutive addresses from obaseaddr
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mvu_datapath import mvu_pkg::*; (
    input  logic    mvu_ext,
    input  logic    rst,
    input  logic    acc_clr,
    input  logic    acc_en,
    input  logic    seg_end,
    input  logic    wrw_en,
    input  addr_t   wrw_addr,
    input  word_t   wrw_word,
    input  addr_t   rdw_addr,
    input  word_t   rdd_word,
    input  scaler_t scaler_b,
    input  addr_t   obaseaddr,
    output logic    wb_en,
    output addr_t   wb_addr,
    output word_t   wb_word
);

    word_t wmem [2**BADDR];
    word_t rdw_word;
    acc_t  dot_sum;
    acc_t  dot_q;                   // Registered dot product
    acc_t  acc_q;
    acc_t  acc_sum;
    acc_t  tot_q;                   // Segment total for the scaler
    logic  tot_vld;
    addr_t out_idx;

    // Weight memory with registered read
    always_ff @(posedge mvu_ext) begin
        if (wrw_en) begin
            wmem[wrw_addr] <= wrw_word;
        end
        rdw_word <= wmem[rdw_addr];
    end

    always_comb begin
        dot_sum = '0;
        for (int i = 0; i < N_LANES; i++) begin
            dot_sum = dot_sum + acc_t'(rdw_word[i*BELEM +: BELEM]) *
                                acc_t'(rdd_word[i*BELEM +: BELEM]);
        end
    end

    // Clear arrives together with the first product of a job
    assign acc_sum = (acc_clr ? '0 : acc_q) + dot_q;

    always_ff @(posedge mvu_ext) begin
        if (rst) begin
            acc_q   <= '0;
            tot_vld <= 1'b0;
            wb_en   <= 1'b0;
            out_idx <= '0;
        end else begin
            tot_vld <= acc_en & seg_end;
            wb_en   <= tot_vld;
            if (acc_en) begin
                acc_q <= seg_end ? '0 : acc_sum;    // Restart after each segment
            end else if (acc_clr) begin
                acc_q <= '0;
            end
            if (acc_clr) begin
                out_idx <= '0;
            end else if (tot_vld) begin
                out_idx <= out_idx + addr_t'(1);
            end
        end
    end

    always_ff @(posedge mvu_ext) begin
        dot_q <= dot_sum;
        if (acc_en & seg_end) begin
            tot_q <= acc_sum;
        end
        wb_word <= word_t'(tot_q) * word_t'(scaler_b);
        wb_addr <= obaseaddr + out_idx;
    end

endmodule

// File: rtl/mvu_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Single matrix-vector unit, no back-pressure
// Host writes to the data memory are lost while wrc_grnt is low
// Configuration is sampled on start only
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mvu_top import mvu_pkg::*; (
    input  logic    mvu_ext,
    input  logic    rst,
    input  logic    start,
    input  cnt_t    countdown,
    input  addr_t   wbaseaddr,
    input  addr_t   ibaseaddr,
    input  addr_t   obaseaddr,
    input  len_t    wlength,
    input  len_t    ilength,
    input  addr_t   wjump,
    input  addr_t   ijump,
    input  scaler_t scaler_b,
    input  logic    wrw_en,
    input  addr_t   wrw_addr,
    input  word_t   wrw_word,
    input  logic    wrc_en,
    input  addr_t   wrc_addr,
    input  word_t   wrc_word,
    output logic    wrc_grnt,
    input  logic    rdc_en,
    input  addr_t   rdc_addr,
    output word_t   rdc_word,
    output logic    done,
    output logic    irq
);

    logic    start_q;
    cnt_t    countdown_q;
    addr_t   wbaseaddr_q, ibaseaddr_q, obaseaddr_q;
    len_t    wlength_q, ilength_q;
    addr_t   wjump_q, ijump_q;
    scaler_t scaler_b_q;

    logic    run;
    addr_t   rdw_addr;          // Weight read address
    addr_t   rdd_addr;          // Input read address
    logic    w_on_j;            // Last element of a weight segment
    logic    acc_clr, acc_en, seg_end;
    logic    wb_en;
    addr_t   wb_addr;
    word_t   wb_word;
    word_t   rdd_word;

    mvu_param_buf u_param_buf (
        .mvu_ext     (mvu_ext),
        .rst         (rst),
        .start       (start),
        .countdown   (countdown),
        .wbaseaddr   (wbaseaddr),
        .ibaseaddr   (ibaseaddr),
        .obaseaddr   (obaseaddr),
        .wlength     (wlength),
        .ilength     (ilength),
        .wjump       (wjump),
        .ijump       (ijump),
        .scaler_b    (scaler_b),
        .start_q     (start_q),
        .countdown_q (countdown_q),
        .wbaseaddr_q (wbaseaddr_q),
        .ibaseaddr_q (ibaseaddr_q),
        .obaseaddr_q (obaseaddr_q),
        .wlength_q   (wlength_q),
        .ilength_q   (ilength_q),
        .wjump_q     (wjump_q),
        .ijump_q     (ijump_q),
        .scaler_b_q  (scaler_b_q)
    );

    mvu_controller u_controller (
        .mvu_ext   (mvu_ext),
        .rst       (rst),
        .start_q   (start_q),
        .countdown (countdown_q),
        .run       (run),
        .done      (done),
        .irq       (irq)
    );

    mvu_agu wagu (
        .mvu_ext (mvu_ext),
        .rst     (rst),
        .clr     (start_q),
        .step    (run),
        .base    (wbaseaddr_q),
        .length  (wlength_q),
        .jump    (wjump_q),
        .addr    (rdw_addr),
        .on_j    (w_on_j)
    );

    mvu_agu iagu (
        .mvu_ext (mvu_ext),
        .rst     (rst),
        .clr     (start_q),
        .step    (run),
        .base    (ibaseaddr_q),
        .length  (ilength_q),
        .jump    (ijump_q),
        .addr    (rdd_addr),
        .on_j    ()                     // Input segment ends steer nothing
    );

    mvu_ctrl_delay u_ctrl_delay (
        .mvu_ext (mvu_ext),
        .rst     (rst),
        .start_q (start_q),
        .run     (run),
        .w_on_j  (w_on_j),
        .acc_clr (acc_clr),
        .acc_en  (acc_en),
        .seg_end (seg_end)
    );

    mvu_datapath u_datapath (
        .mvu_ext   (mvu_ext),
        .rst       (rst),
        .acc_clr   (acc_clr),
        .acc_en    (acc_en),
        .seg_end   (seg_end),
        .wrw_en    (wrw_en),
        .wrw_addr  (wrw_addr),
        .wrw_word  (wrw_word),
        .rdw_addr  (rdw_addr),
        .rdd_word  (rdd_word),
        .scaler_b  (scaler_b_q),
        .obaseaddr (obaseaddr_q),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_word   (wb_word)
    );

    mvu_data_mem u_data_mem (
        .mvu_ext  (mvu_ext),
        .rdd_addr (rdd_addr),
        .rdd_word (rdd_word),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_word  (wb_word),
        .wrc_en   (wrc_en),
        .wrc_addr (wrc_addr),
        .wrc_word (wrc_word),
        .wrc_grnt (wrc_grnt),
        .rdc_en   (rdc_en),
        .rdc_addr (rdc_addr),
        .rdc_word (rdc_word)
    );

endmodule

// File: include/mvu_tb_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~
// Testbench tasks, included inside mvu_tb
// Every task starts and ends just after a falling clock edge
// ~~~~~~~~~~~~~~~~~~~~
`ifndef MVU_TB_TASKS_SVH
`define MVU_TB_TASKS_SVH

// Galois LFSR, taps 32 30 26 25
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
endfunction

task automatic take_random(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        value = {value[30:0], lfsr_state[0]};   // One step per bit
    end
endtask

task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
    if (actual !== expected) begin
        $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first mismatch");
    end
endtask

task automatic write_weight(input addr_t addr, input word_t word);
    wrw_en   = 1'b1;
    wrw_addr = addr;
    wrw_word = word;
    w_ref[addr] = word;
    @(negedge mvu_ext);
    wrw_en = 1'b0;
endtask

task automatic write_data(input addr_t addr, input word_t word);
    check(wrc_grnt, 1'b1, "host write grant");    // No job is writing back here
    wrc_en   = 1'b1;
    wrc_addr = addr;
    wrc_word = word;
    d_ref[addr] = word;
    @(negedge mvu_ext);
    wrc_en = 1'b0;
endtask

task automatic read_data(input addr_t addr, output word_t word);
    rdc_en   = 1'b1;
    rdc_addr = addr;
    @(negedge mvu_ext);
    rdc_en = 1'b0;
    word   = rdc_word;                          // Registered read
endtask

task automatic fill_weights(input addr_t base, input int n);
    logic [31:0] value;
    for (int i = 0; i < n; i++) begin
        take_random(32, value);
        write_weight(base + addr_t'(i), value);
    end
endtask

task automatic fill_data(input addr_t base, input int n);
    logic [31:0] value;
    for (int i = 0; i < n; i++) begin
        take_random(32, value);
        write_data(base + addr_t'(i), value);
    end
endtask

function automatic logic [31:0] lane_dot(input word_t w, input word_t d);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < N_LANES; i++) begin
        sum = sum + 32'(w[i*BELEM +: BELEM]) * 32'(d[i*BELEM +: BELEM]);
    end
    return sum;
endfunction

// Walks both address patterns once per run cycle
task automatic model_job(input cnt_t cd, input addr_t wb, input addr_t ib, input len_t wl,
                         input len_t il, input addr_t wj, input addr_t ij, input scaler_t sc,
                         output int n_out);
    addr_t       woff;
    addr_t       ioff;
    len_t        wcnt;
    len_t        icnt;
    logic [31:0] sum;
    woff  = '0;
    ioff  = '0;
    wcnt  = '0;
    icnt  = '0;
    sum   = '0;
    n_out = 0;
    for (int c = 0; c < int'(cd); c++) begin
        sum = sum + lane_dot(w_ref[addr_t'(wb + woff)], d_ref[addr_t'(ib + ioff)]);
        if (wcnt == wl) begin
            exp_out[n_out] = sum * 32'(sc);
            n_out++;
            sum  = '0;
            woff = woff + wj;
            wcnt = '0;
        end else begin
            woff = woff + addr_t'(1);
            wcnt = wcnt + len_t'(1);
        end
        if (icnt == il) begin
            ioff = ioff + ij;
            icnt = '0;
        end else begin
            ioff = ioff + addr_t'(1);
            icnt = icnt + len_t'(1);
        end
    end
endtask

task automatic run_job(input cnt_t cd, input addr_t wb, input addr_t ib, input addr_t ob,
                       input len_t wl, input len_t il, input addr_t wj, input addr_t ij,
                       input scaler_t sc);
    int    n_out;
    int    cycles;
    int    grant_lows;
    word_t got;
    model_job(cd, wb, ib, wl, il, wj, ij, sc, n_out);
    countdown = cd;
    wbaseaddr = wb;
    ibaseaddr = ib;
    obaseaddr = ob;
    wlength   = wl;
    ilength   = il;
    wjump     = wj;
    ijump     = ij;
    scaler_b  = sc;
    start     = 1'b1;
    @(negedge mvu_ext);
    start     = 1'b0;
    countdown = ~cd;                            // Job must run on the latched values
    wbaseaddr = ~wb;
    ibaseaddr = ~ib;
    obaseaddr = ~ob;
    wlength   = ~wl;
    ilength   = ~il;
    wjump     = ~wj;
    ijump     = ~ij;
    scaler_b  = ~sc;
    cycles     = 1;
    grant_lows = 0;
    while (done !== 1'b1) begin
        if (cycles >= 2) begin
            check(irq, 1'b0, "irq while the job runs");
        end
        if (wrc_grnt !== 1'b1) begin
            grant_lows++;
        end
        @(negedge mvu_ext);
        cycles++;
    end
    check(cycles, int'(cd) + 1, "cycles from start to done");
    check(irq, 1'b1, "irq together with done");
    repeat (PIPE_DEPTH) begin
        if (wrc_grnt !== 1'b1) begin
            grant_lows++;
        end
        @(negedge mvu_ext);
        check(done, 1'b0, "done pulse length");
    end
    check(grant_lows, n_out, "cycles with the host grant low");
    for (int k = 0; k < n_out; k++) begin
        read_data(ob + addr_t'(k), got);
        check(got, exp_out[k], $sformatf("output %0d", k));
    end
endtask

`endif

// File: verification/mvu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Directed tests for the matrix-vector unit
// Results are read back through the host port after each job
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mvu_tb import mvu_pkg::*; ();

    localparam int N_TESTS       = 5;
    localparam int MAX_COUNTDOWN = 16;
    localparam int LOAD_CYCLES   = 100;     // Memory loads and readback per test
    localparam int WATCHDOG_NS   = 2 * N_TESTS * (MAX_COUNTDOWN + PIPE_DEPTH + LOAD_CYCLES) * 100;

    logic    mvu_ext;
    logic    rst;
    logic    start;
    cnt_t    countdown;
    addr_t   wbaseaddr, ibaseaddr, obaseaddr;
    len_t    wlength, ilength;
    addr_t   wjump, ijump;
    scaler_t scaler_b;
    logic    wrw_en;
    addr_t   wrw_addr;
    word_t   wrw_word;
    logic    wrc_en;
    addr_t   wrc_addr;
    word_t   wrc_word;
    logic    wrc_grnt;
    logic    rdc_en;
    addr_t   rdc_addr;
    word_t   rdc_word;
    logic    done;
    logic    irq;

    word_t       w_ref [2**BADDR];      // Shadow of the weight memory
    word_t       d_ref [2**BADDR];      // Shadow of the data memory
    word_t       exp_out [2**BADDR];
    logic [31:0] lfsr_state;

    `include "mvu_tb_tasks.svh"

    mvu_top dut (
        .mvu_ext   (mvu_ext),
        .rst       (rst),
        .start     (start),
        .countdown (countdown),
        .wbaseaddr (wbaseaddr),
        .ibaseaddr (ibaseaddr),
        .obaseaddr (obaseaddr),
        .wlength   (wlength),
        .ilength   (ilength),
        .wjump     (wjump),
        .ijump     (ijump),
        .scaler_b  (scaler_b),
        .wrw_en    (wrw_en),
        .wrw_addr  (wrw_addr),
        .wrw_word  (wrw_word),
        .wrc_en    (wrc_en),
        .wrc_addr  (wrc_addr),
        .wrc_word  (wrc_word),
        .wrc_grnt  (wrc_grnt),
        .rdc_en    (rdc_en),
        .rdc_addr  (rdc_addr),
        .rdc_word  (rdc_word),
        .done      (done),
        .irq       (irq)
    );

    initial begin
        mvu_ext = 1'b0;
        forever #50 mvu_ext = ~mvu_ext;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    task automatic test_reset_host();
        logic [31:0] value;
        word_t       got;
        repeat (3) begin
            check(done, 1'b0, "done after reset");
            check(irq, 1'b0, "irq after reset");
            check(wrc_grnt, 1'b1, "grant after reset");
            @(negedge mvu_ext);
        end
        take_random(32, value);
        write_data(6'd33, value);
        read_data(6'd33, got);
        check(got, value, "host readback");
    endtask

    task automatic test_single_segment();
        for (int i = 0; i < 4; i++) begin
            write_weight(addr_t'(i), 32'h0101_0101 * (i + 1));
            write_data(addr_t'(8 + i), 32'h0403_0201 + i);
        end
        run_job(8'd4, 6'd0, 6'd8, 6'd40, 4'd3, 4'd3, 6'd1, 6'd1, 8'd1);
    endtask

    task automatic test_multi_segment();
        logic [31:0] value;
        fill_weights(6'd0, 12);
        fill_data(6'd16, 12);
        take_random(BSCALER, value);
        run_job(8'd12, 6'd0, 6'd16, 6'd48, 4'd3, 4'd3, 6'd1, 6'd1, scaler_t'(value) | 8'd1);
    endtask

    // Weights at 0,1,4,5,8,... while the input vector repeats
    task automatic test_jumps();
        logic [31:0] value;
        fill_weights(6'd0, 14);
        fill_data(6'd20, 4);
        take_random(BSCALER, value);
        run_job(8'd8, 6'd0, 6'd20, 6'd56, 4'd1, 4'd3, 6'd3, 6'd61, scaler_t'(value));
    endtask

    task automatic test_irq_latch();
        repeat (5) begin
            check(irq, 1'b1, "irq held after done");
            @(negedge mvu_ext);
        end
        run_job(8'd6, 6'd2, 6'd20, 6'd60, 4'd2, 4'd2, 6'd1, 6'd62, 8'd3);
    endtask

    initial begin
        lfsr_state = 32'd17;
        rst       = 1'b1;
        start     = 1'b0;
        countdown = '0;
        wbaseaddr = '0;
        ibaseaddr = '0;
        obaseaddr = '0;
        wlength   = '0;
        ilength   = '0;
        wjump     = '0;
        ijump     = '0;
        scaler_b  = '0;
        wrw_en    = 1'b0;
        wrw_addr  = '0;
        wrw_word  = '0;
        wrc_en    = 1'b0;
        wrc_addr  = '0;
        wrc_word  = '0;
        rdc_en    = 1'b0;
        rdc_addr  = '0;
        repeat (3) @(posedge mvu_ext);      // Three reset cycles
        @(negedge mvu_ext);
        rst = 1'b0;
        test_reset_host();
        test_single_segment();
        test_multi_segment();
        test_jumps();
        test_irq_latch();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
rtl/mvu_pkg.sv
rtl/mvu_param_buf.sv
rtl/mvu_controller.sv
rtl/mvu_agu.sv
rtl/mvu_ctrl_delay.sv
rtl/mvu_data_mem.sv
rtl/mvu_datapath.sv
rtl/mvu_top.sv
verification/mvu_tb.sv
